// File: hdl/hart_pkg.sv
package hart_pkg;

  localparam int XLEN = 32; // datapath width of the whole hart

  typedef logic [XLEN-1:0] word_t; // data word or byte address
  typedef logic [31:0] inst_t; // raw instruction word as fetched
  typedef logic [4:0] reg_addr_t; // architectural register index

  // alu operations, pass_b carries the lui immediate straight through
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_OP = 7'b0110011; // register-register alu
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // register-immediate alu
  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_LOAD = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011; // only ebreak is recognised

  // funct3 values of the alu group
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_WORD = 3'b010; // lw and sw, the only width kept

  localparam inst_t EBREAK_INST = 32'h00100073; // halts the hart when it reaches decode

  localparam word_t RESET_ADDR = 32'h00000000; // first fetch address

endpackage

// File: hdl/stage_if.sv
`timescale 1ns/1ps

// decoded instruction and its operands, held in the decode/execute register
interface ex_bus_if import hart_pkg::*; ();
  logic valid; // low for a bubble
  inst_t inst;
  word_t pc;
  word_t op_a; // rs1 value
  word_t op_b; // rs2 value or the selected immediate
  word_t store_data; // rs2 value that a sw writes to memory
  alu_op_e alu_op;
  reg_addr_t rd;
  logic reg_write;
  logic mem_read;
  logic mem_write;

  modport src(output valid, inst, pc, op_a, op_b, store_data, alu_op, rd, reg_write,
              mem_read, mem_write);
  modport dst(input valid, inst, pc, op_a, op_b, store_data, alu_op, rd, reg_write,
              mem_read, mem_write);
endinterface

// execute results, held in the execute/memory register
interface wb_bus_if import hart_pkg::*; ();
  logic valid;
  inst_t inst;
  word_t pc;
  word_t alu_result; // also the data memory address of lw and sw
  reg_addr_t rd;
  logic reg_write;
  logic mem_read; // writeback takes the load data instead of the alu result
  logic mem_write;

  modport src(output valid, inst, pc, alu_result, rd, reg_write, mem_read, mem_write);
  modport dst(input valid, inst, pc, alu_result, rd, reg_write, mem_read, mem_write);
endinterface

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import hart_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_stall, // decode waits on a source, hold pc and the fetch/decode register
  input  inst_t i_imem_rdata,
  output word_t o_imem_raddr,
  output logic  o_id_valid,
  output inst_t o_id_inst,
  output word_t o_id_pc
);

  word_t pc_q;
  logic halted_q; // set once an ebreak has passed decode, fetch then stays frozen
  logic halt;

  // ebreak sitting in decode stops the pc right away, nothing after it may enter
  assign halt = halted_q | (o_id_valid & (o_id_inst == EBREAK_INST));
  assign o_imem_raddr = pc_q; // combinational instruction port

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q <= RESET_ADDR;
      halted_q <= 1'b0;
      o_id_valid <= 1'b0; // decode sees a bubble in the first cycle after reset
    end else if (!i_stall) begin
      halted_q <= halt;
      if (!halt) pc_q <= pc_q + word_t'(4); // no branches, so the pc only steps by four
      o_id_valid <= !halt; // the word fetched behind an ebreak never gets decoded
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_id_inst <= i_imem_rdata;
      o_id_pc <= pc_q;
    end
  end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file import hart_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  reg_addr_t i_rs1_raddr,
  input  reg_addr_t i_rs2_raddr,
  input  logic      i_rd_wen,
  input  reg_addr_t i_rd_waddr,
  input  word_t     i_rd_wdata,
  output word_t     o_rs1_rdata,
  output word_t     o_rs2_rdata
);

  word_t regs [1:31]; // x0 has no storage

  // one read port, x0 reads zero and a same-cycle write is passed through
  function automatic word_t read_port(input reg_addr_t raddr);
    if (raddr == '0) return '0;
    if (i_rd_wen && (i_rd_waddr == raddr)) return i_rd_wdata; // covers distance three
    return regs[raddr];
  endfunction

  assign o_rs1_rdata = read_port(i_rs1_raddr);
  assign o_rs2_rdata = read_port(i_rs2_raddr);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0; // programs start from a zeroed register set
    end else if (i_rd_wen && (i_rd_waddr != '0)) begin
      regs[i_rd_waddr] <= i_rd_wdata; // writes to x0 are dropped
    end
  end

endmodule

// File: hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import hart_pkg::*; (
  input  reg_addr_t i_rs1,
  input  reg_addr_t i_rs2,
  input  logic      i_uses_rs1,
  input  logic      i_uses_rs2,
  input  reg_addr_t i_ex_rd, // destination of the instruction in execute
  input  logic      i_ex_reg_write,
  input  reg_addr_t i_mem_rd, // destination of the instruction in memory
  input  logic      i_mem_reg_write,
  output logic      o_stall
);

  // a source waits when an older instruction still in flight will write it
  // writeback is not checked, the register file passes its write through
  function automatic logic waits(input reg_addr_t rs, input logic uses);
    logic ex_hit;
    logic mem_hit;
    ex_hit = i_ex_reg_write && (i_ex_rd == rs);
    mem_hit = i_mem_reg_write && (i_mem_rd == rs);
    return uses && (rs != '0) && (ex_hit || mem_hit); // x0 never carries a dependency
  endfunction

  assign o_stall = waits(i_rs1, i_uses_rs1) | waits(i_rs2, i_uses_rs2);

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import hart_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_stall,
  input  logic      i_valid, // fetch/decode register holds a real instruction
  input  inst_t     i_inst,
  input  word_t     i_pc,
  input  word_t     i_rs1_rdata,
  input  word_t     i_rs2_rdata,
  output reg_addr_t o_rs1,
  output reg_addr_t o_rs2,
  output logic      o_uses_rs1,
  output logic      o_uses_rs2,
  ex_bus_if.src     ex
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic alt; // instruction bit 30, selects sub and sra
  word_t imm_i;
  word_t imm_s;
  word_t imm_u;
  word_t op_b; // second alu operand after selection
  alu_op_e alu_op;
  logic reg_write;
  logic mem_read;
  logic mem_write;
  logic uses_rs1;
  logic uses_rs2;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign alt = i_inst[30];
  assign o_rs1 = i_inst[19:15]; // register file is read every cycle from these fields
  assign o_rs2 = i_inst[24:20];

  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_u = {i_inst[31:12], 12'b0};

  // alu group decode, shared by the register and the immediate forms
  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic f7_alt,
                                         input logic is_reg);
    case (f3)
      F3_ADD_SUB: return (f7_alt && is_reg) ? ALU_SUB : ALU_ADD; // addi has no sub form
      F3_SLL: return ALU_SLL;
      F3_SLT: return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR: return ALU_XOR;
      F3_SRL_SRA: return f7_alt ? ALU_SRA : ALU_SRL; // srai keeps bit 30 in its immediate
      F3_OR: return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // control decode, anything outside the subset leaves every enable low
  always_comb begin
    alu_op = ALU_ADD; // address add for lw and sw
    op_b = imm_i;
    reg_write = 1'b0;
    mem_read = 1'b0;
    mem_write = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      OPC_OP: begin
        alu_op = alu_decode(funct3, alt, 1'b1);
        op_b = i_rs2_rdata;
        reg_write = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      OPC_OP_IMM: begin
        alu_op = alu_decode(funct3, alt, 1'b0);
        reg_write = 1'b1;
        uses_rs1 = 1'b1;
      end
      OPC_LUI: begin
        alu_op = ALU_PASS_B; // rs1 field is part of the immediate here
        op_b = imm_u;
        reg_write = 1'b1;
      end
      OPC_LOAD: begin
        if (funct3 == F3_WORD) begin
          mem_read = 1'b1;
          reg_write = 1'b1;
          uses_rs1 = 1'b1;
        end
      end
      OPC_STORE: begin
        op_b = imm_s;
        if (funct3 == F3_WORD) begin
          mem_write = 1'b1;
          uses_rs1 = 1'b1;
          uses_rs2 = 1'b1; // store data comes from rs2
        end
      end
      OPC_SYSTEM: begin
        // ebreak moves on with no enables, fetch has already frozen the pc
      end
      default: begin
      end
    endcase
  end

  // a bubble in the fetch/decode register must not stall anything
  assign o_uses_rs1 = i_valid & uses_rs1;
  assign o_uses_rs2 = i_valid & uses_rs2;

  always_ff @(posedge i_clk) begin
    if (i_rst || i_stall) begin
      ex.valid <= 1'b0; // bubble, the stalled instruction stays in fetch/decode
      ex.reg_write <= 1'b0;
      ex.mem_read <= 1'b0;
      ex.mem_write <= 1'b0;
    end else begin
      ex.valid <= i_valid;
      ex.reg_write <= i_valid & reg_write;
      ex.mem_read <= i_valid & mem_read;
      ex.mem_write <= i_valid & mem_write;
    end
  end

  always_ff @(posedge i_clk) begin
    ex.inst <= i_inst;
    ex.pc <= i_pc;
    ex.op_a <= i_rs1_rdata;
    ex.op_b <= op_b;
    ex.store_data <= i_rs2_rdata;
    ex.alu_op <= alu_op;
    ex.rd <= i_inst[11:7];
  end

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import hart_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  ex_bus_if.dst     ex,
  output reg_addr_t o_ex_rd,
  output logic      o_ex_reg_write,
  wb_bus_if.src     wb,
  output word_t     o_dmem_addr,
  output logic      o_dmem_ren,
  output logic      o_dmem_wen,
  output word_t     o_dmem_wdata
);

  word_t alu_result;
  logic [4:0] shamt; // only the low five bits of op_b count for shifts
  word_t store_data_q;

  assign shamt = ex.op_b[4:0];

  always_comb begin
    case (ex.alu_op)
      ALU_ADD: alu_result = ex.op_a + ex.op_b;
      ALU_SUB: alu_result = ex.op_a - ex.op_b;
      ALU_AND: alu_result = ex.op_a & ex.op_b;
      ALU_OR: alu_result = ex.op_a | ex.op_b;
      ALU_XOR: alu_result = ex.op_a ^ ex.op_b;
      ALU_SLT: alu_result = word_t'($signed(ex.op_a) < $signed(ex.op_b));
      ALU_SLTU: alu_result = word_t'(ex.op_a < ex.op_b);
      ALU_SLL: alu_result = ex.op_a << shamt;
      ALU_SRL: alu_result = ex.op_a >> shamt;
      ALU_SRA: alu_result = word_t'($signed(ex.op_a) >>> shamt);
      ALU_PASS_B: alu_result = ex.op_b; // lui
      default: alu_result = '0;
    endcase
  end

  // the hazard unit compares decode sources against this destination
  assign o_ex_rd = ex.rd;
  assign o_ex_reg_write = ex.reg_write; // already low for bubbles

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wb.valid <= 1'b0;
      wb.reg_write <= 1'b0;
      wb.mem_read <= 1'b0;
      wb.mem_write <= 1'b0;
    end else begin
      wb.valid <= ex.valid;
      wb.reg_write <= ex.reg_write;
      wb.mem_read <= ex.mem_read;
      wb.mem_write <= ex.mem_write;
    end
  end

  always_ff @(posedge i_clk) begin
    wb.inst <= ex.inst;
    wb.pc <= ex.pc;
    wb.alu_result <= alu_result;
    wb.rd <= ex.rd;
    store_data_q <= ex.store_data; // only the memory port needs it, so it stays here
  end

  // memory stage drives the data port straight from the execute/memory register
  assign o_dmem_addr = wb.alu_result;
  assign o_dmem_ren = wb.mem_read;
  assign o_dmem_wen = wb.mem_write; // decode never sets both for one instruction
  assign o_dmem_wdata = store_data_q;

endmodule

// File: hdl/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage import hart_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  wb_bus_if.dst     wb,
  input  word_t     i_dmem_rdata, // load data, valid in the same cycle as the read enable
  output logic      o_rd_wen,
  output reg_addr_t o_rd_waddr,
  output word_t     o_rd_wdata,
  output logic      o_retire_valid,
  output inst_t     o_retire_inst,
  output word_t     o_retire_pc,
  output reg_addr_t o_retire_rd_waddr,
  output word_t     o_retire_rd_wdata,
  output logic      o_retire_halt
);

  logic valid_q;
  logic reg_write_q;
  inst_t inst_q;
  word_t pc_q;
  reg_addr_t rd_q;
  word_t result_q; // final register value, load data or alu result

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid_q <= 1'b0;
      reg_write_q <= 1'b0;
    end else begin
      valid_q <= wb.valid;
      reg_write_q <= wb.reg_write;
    end
  end

  always_ff @(posedge i_clk) begin
    inst_q <= wb.inst;
    pc_q <= wb.pc;
    rd_q <= wb.rd;
    result_q <= wb.mem_read ? i_dmem_rdata : wb.alu_result; // load data is sampled here
  end

  assign o_rd_wen = valid_q & reg_write_q;
  assign o_rd_waddr = rd_q;
  assign o_rd_wdata = result_q;

  // one retire per instruction leaving the pipe, the write lands at the end of this cycle
  assign o_retire_valid = valid_q;
  assign o_retire_inst = inst_q;
  assign o_retire_pc = pc_q;
  assign o_retire_rd_waddr = o_rd_wen ? rd_q : '0; // stores, ebreak and unknown opcodes report x0
  assign o_retire_rd_wdata = result_q;
  assign o_retire_halt = valid_q & (inst_q == EBREAK_INST);

endmodule

// File: hdl/hart_top.sv
`timescale 1ns/1ps

module hart_top import hart_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  inst_t     i_imem_rdata,
  input  word_t     i_dmem_rdata,
  output word_t     o_imem_raddr,
  output word_t     o_dmem_addr,
  output word_t     o_dmem_wdata,
  output logic      o_dmem_ren,
  output logic      o_dmem_wen,
  output logic      o_retire_valid,
  output inst_t     o_retire_inst,
  output word_t     o_retire_pc,
  output reg_addr_t o_retire_rd_waddr,
  output word_t     o_retire_rd_wdata,
  output logic      o_retire_halt
);

  logic stall;
  logic id_valid;
  inst_t id_inst;
  word_t id_pc;
  reg_addr_t rs1;
  reg_addr_t rs2;
  logic uses_rs1;
  logic uses_rs2;
  word_t rs1_rdata;
  word_t rs2_rdata;
  reg_addr_t ex_rd;
  logic ex_reg_write;
  logic rd_wen;
  reg_addr_t rd_waddr;
  word_t rd_wdata;

  ex_bus_if ex_bus(); // decode/execute register contents
  wb_bus_if wb_bus(); // execute/memory register contents, seen as the memory stage

  fetch_stage u_fetch (
    .i_clk(i_clk), .i_rst(i_rst), .i_stall(stall), .i_imem_rdata(i_imem_rdata),
    .o_imem_raddr(o_imem_raddr), .o_id_valid(id_valid), .o_id_inst(id_inst), .o_id_pc(id_pc)
  );

  decode_stage u_decode (
    .i_clk(i_clk), .i_rst(i_rst), .i_stall(stall), .i_valid(id_valid), .i_inst(id_inst),
    .i_pc(id_pc), .i_rs1_rdata(rs1_rdata), .i_rs2_rdata(rs2_rdata), .o_rs1(rs1), .o_rs2(rs2),
    .o_uses_rs1(uses_rs1), .o_uses_rs2(uses_rs2), .ex(ex_bus.src)
  );

  reg_file u_reg_file (
    .i_clk(i_clk), .i_rst(i_rst), .i_rs1_raddr(rs1), .i_rs2_raddr(rs2), .i_rd_wen(rd_wen),
    .i_rd_waddr(rd_waddr), .i_rd_wdata(rd_wdata), .o_rs1_rdata(rs1_rdata),
    .o_rs2_rdata(rs2_rdata)
  );

  // memory stage destination comes straight off the execute/memory register
  hazard_unit u_hazard (
    .i_rs1(rs1), .i_rs2(rs2), .i_uses_rs1(uses_rs1), .i_uses_rs2(uses_rs2), .i_ex_rd(ex_rd),
    .i_ex_reg_write(ex_reg_write), .i_mem_rd(wb_bus.rd), .i_mem_reg_write(wb_bus.reg_write),
    .o_stall(stall)
  );

  execute_stage u_execute (
    .i_clk(i_clk), .i_rst(i_rst), .ex(ex_bus.dst), .o_ex_rd(ex_rd),
    .o_ex_reg_write(ex_reg_write), .wb(wb_bus.src), .o_dmem_addr(o_dmem_addr),
    .o_dmem_ren(o_dmem_ren), .o_dmem_wen(o_dmem_wen), .o_dmem_wdata(o_dmem_wdata)
  );

  writeback_stage u_writeback (
    .i_clk(i_clk), .i_rst(i_rst), .wb(wb_bus.dst), .i_dmem_rdata(i_dmem_rdata),
    .o_rd_wen(rd_wen), .o_rd_waddr(rd_waddr), .o_rd_wdata(rd_wdata),
    .o_retire_valid(o_retire_valid), .o_retire_inst(o_retire_inst), .o_retire_pc(o_retire_pc),
    .o_retire_rd_waddr(o_retire_rd_waddr), .o_retire_rd_wdata(o_retire_rd_wdata),
    .o_retire_halt(o_retire_halt)
  );

endmodule

// File: verif/hart_sva.sv
`timescale 1ns/1ps

module hart_sva import hart_pkg::*; (
  input logic  i_clk,
  input logic  i_rst,
  input logic  o_dmem_ren,
  input logic  o_dmem_wen,
  input logic  o_retire_valid,
  input word_t o_retire_pc,
  input logic  o_retire_halt
);

  word_t last_pc; // pc of the previous retire
  logic have_last;
  logic halted;
  logic [2:0] since_reset; // saturating count of cycles after reset

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      have_last <= 1'b0;
      halted <= 1'b0;
      since_reset <= 3'd0;
    end else begin
      if (since_reset != 3'd7) since_reset <= since_reset + 3'd1;
      if (o_retire_valid) begin
        last_pc <= o_retire_pc;
        have_last <= 1'b1;
        if (o_retire_halt) halted <= 1'b1;
      end
    end
  end

  a_dmem_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
    !(o_dmem_ren && o_dmem_wen))
    else $error("data memory read and write enables high together");

  // no branches, so retires walk through memory one word at a time
  a_pc_step: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_retire_valid && have_last && !halted) |-> (o_retire_pc == last_pc + 32'd4))
    else $error("retired pc did not step by four");

  a_reset_quiet: assert property (@(posedge i_clk) disable iff (i_rst)
    (since_reset < 3'd4) |-> !o_retire_valid)
    else $error("retire within four cycles of reset");

endmodule

bind hart_top hart_sva u_sva (.*);

// File: verif/tb_hart.sv
`timescale 1ns/1ps

module tb_hart import hart_pkg::*; ();

  localparam int NUM_TESTS = 6;
  localparam int CYCLES_PER_TEST = 200; // watchdog budget for one test
  localparam int CLK_PERIOD = 8;
  localparam int IMEM_WORDS = 64;
  localparam int DMEM_WORDS = 256;
  localparam inst_t NOP_INST = 32'h00000013; // addi x0, x0, 0

  logic i_clk;
  logic i_rst;
  inst_t i_imem_rdata;
  word_t i_dmem_rdata;
  word_t o_imem_raddr;
  word_t o_dmem_addr;
  word_t o_dmem_wdata;
  logic o_dmem_ren;
  logic o_dmem_wen;
  logic o_retire_valid;
  inst_t o_retire_inst;
  word_t o_retire_pc;
  reg_addr_t o_retire_rd_waddr;
  word_t o_retire_rd_wdata;
  logic o_retire_halt;

  inst_t imem [IMEM_WORDS];
  word_t dmem [DMEM_WORDS];
  word_t ref_regs [32]; // architectural state of the reference interpreter
  word_t ref_dmem [DMEM_WORDS];
  logic [31:0] lfsr_state;
  int prog_len;
  int mismatch_count;
  int failure_count;

  // expected retire stream and store stream, filled by the interpreter
  word_t exp_pc [$];
  inst_t exp_inst [$];
  reg_addr_t exp_rd [$];
  word_t exp_wdata [$];
  logic exp_halt [$];
  word_t exp_st_addr [$];
  word_t exp_st_data [$];

  hart_top uut (.*);

  // both memories answer in the same cycle, data memory only while its read enable is high
  assign i_imem_rdata = imem[o_imem_raddr[7:2]];
  assign i_dmem_rdata = o_dmem_ren ? dmem[o_dmem_addr[9:2]] : '0;

  always @(posedge i_clk) begin
    if (o_dmem_wen) dmem[o_dmem_addr[9:2]] = o_dmem_wdata; // a store lands at the edge
  end

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("error: watchdog expired before all tests finished");
    $display("Simulation FAILED");
    $finish;
  end

  // every word differs, so a load from the wrong address shows
  function automatic word_t fill_word(input int unsigned idx);
    return 32'hA5C30000 ^ (word_t'(idx) << 2);
  endfunction

  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ 32'h80200003;
    return out;
  endfunction

  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  function automatic inst_t enc_r(input logic [6:0] f7, input reg_addr_t rs2, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic inst_t enc_i(input logic [6:0] opc, input logic [11:0] imm,
                                  input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                  input reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  task automatic clear_program();
    for (int i = 0; i < IMEM_WORDS; i++) imem[i] = NOP_INST;
    prog_len = 0;
  endtask

  task automatic emit(input inst_t ins);
    imem[prog_len] = ins;
    prog_len++;
  endtask

  // lui plus addi, the upper part is rounded for the sign of the low twelve bits
  task automatic load_const(input reg_addr_t rd, input word_t value);
    word_t upper;
    upper = (value + 32'h800) >> 12;
    emit({upper[19:0], rd, OPC_LUI});
    emit(enc_i(OPC_OP_IMM, value[11:0], rd, 3'b000, rd));
  endtask

  task automatic report_failure(input string msg);
    failure_count++;
    $display("error: %s", msg);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_inst(input string name, input inst_t got, input inst_t exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  // rv32i semantics of the alu group, alt picks sub or the arithmetic shift
  function automatic word_t ref_alu(input logic [2:0] f3, input logic alt, input word_t a,
                                    input word_t b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: return (a < b) ? 32'd1 : 32'd0;
      3'b100: return a ^ b;
      3'b101: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // in-order interpreter over its own state, stops at the first ebreak
  task automatic run_reference();
    word_t pc;
    word_t a;
    word_t b;
    word_t res;
    word_t addr;
    inst_t ins;
    logic wr;
    exp_pc.delete();
    exp_inst.delete();
    exp_rd.delete();
    exp_wdata.delete();
    exp_halt.delete();
    exp_st_addr.delete();
    exp_st_data.delete();
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    for (int i = 0; i < DMEM_WORDS; i++) ref_dmem[i] = fill_word(i);
    pc = RESET_ADDR;
    for (int step = 0; step < IMEM_WORDS; step++) begin
      ins = imem[pc[7:2]];
      a = ref_regs[ins[19:15]];
      b = ref_regs[ins[24:20]];
      res = '0;
      wr = 1'b1;
      case (ins[6:0])
        OPC_OP: res = ref_alu(ins[14:12], ins[30], a, b);
        OPC_OP_IMM: res = ref_alu(ins[14:12], ins[30] && (ins[14:12] == 3'b101), a,
                                  {{20{ins[31]}}, ins[31:20]});
        OPC_LUI: res = {ins[31:12], 12'b0};
        OPC_LOAD: begin
          addr = a + {{20{ins[31]}}, ins[31:20]};
          res = ref_dmem[addr[9:2]];
        end
        OPC_STORE: begin
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          exp_st_addr.push_back(addr);
          exp_st_data.push_back(b);
          ref_dmem[addr[9:2]] = b;
          wr = 1'b0;
        end
        default: wr = 1'b0; // ebreak and anything unknown write nothing
      endcase
      if (ins[11:7] == 5'd0) wr = 1'b0;
      exp_pc.push_back(pc);
      exp_inst.push_back(ins);
      exp_rd.push_back(wr ? ins[11:7] : 5'd0);
      exp_wdata.push_back(res);
      exp_halt.push_back(ins == EBREAK_INST);
      if (wr) ref_regs[ins[11:7]] = res;
      if (ins == EBREAK_INST) break;
      pc = pc + 32'd4;
    end
  endtask

  task automatic check_store();
    if (exp_st_addr.size() == 0) begin
      report_failure("store seen on the data port that the program does not make");
    end else begin
      check_word("o_dmem_addr", o_dmem_addr, exp_st_addr.pop_front());
      check_word("o_dmem_wdata", o_dmem_wdata, exp_st_data.pop_front());
    end
  endtask

  // reset the DUT, then compare every retire and store against the interpreter
  task automatic run_program(input logic check_latency);
    int cycle;
    logic seen_first;
    run_reference();
    for (int i = 0; i < DMEM_WORDS; i++) dmem[i] = fill_word(i);
    @(posedge i_clk);
    #1 i_rst = 1'b1;
    repeat (8) @(posedge i_clk);
    #1 i_rst = 1'b0;
    cycle = 0;
    seen_first = 1'b0;
    while (exp_pc.size() > 0) begin
      @(negedge i_clk);
      if (cycle == 0) begin
        check_bit("o_retire_valid", o_retire_valid, 1'b0);
        check_bit("o_dmem_ren", o_dmem_ren, 1'b0);
        check_bit("o_dmem_wen", o_dmem_wen, 1'b0);
        check_word("o_imem_raddr", o_imem_raddr, RESET_ADDR);
      end
      if (o_dmem_wen) check_store();
      if (o_retire_valid) begin
        if (check_latency && !seen_first && cycle != 4)
          report_failure("first instruction did not retire in the fifth cycle after reset");
        seen_first = 1'b1;
        check_word("o_retire_pc", o_retire_pc, exp_pc.pop_front());
        check_inst("o_retire_inst", o_retire_inst, exp_inst.pop_front());
        check_reg("o_retire_rd_waddr", o_retire_rd_waddr, exp_rd[0]);
        if (exp_rd.pop_front() != 5'd0)
          check_word("o_retire_rd_wdata", o_retire_rd_wdata, exp_wdata[0]);
        void'(exp_wdata.pop_front());
        check_bit("o_retire_halt", o_retire_halt, exp_halt.pop_front());
      end
      cycle++;
    end
    if (exp_st_addr.size() != 0) report_failure("program ended with stores still expected");
    repeat (20) begin
      @(negedge i_clk);
      if (o_retire_valid) report_failure("instruction retired after the halt");
    end
  endtask

  task automatic test_reset();
    clear_program();
    emit(enc_i(OPC_OP_IMM, 12'd5, 5'd0, 3'b000, 5'd1));
    emit(enc_i(OPC_OP_IMM, 12'd7, 5'd0, 3'b000, 5'd2));
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    emit(EBREAK_INST);
    run_program(1'b1);
  endtask

  task automatic test_alu();
    logic [2:0] f3_list [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic [6:0] f7_list [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20,
                                 7'h00, 7'h00};
    clear_program();
    load_const(5'd1, rand_bits(32));
    load_const(5'd2, rand_bits(32));
    for (int i = 0; i < 10; i++)
      emit(enc_r(f7_list[i], 5'd2, 5'd1, f3_list[i], reg_addr_t'(3 + i)));
    // immediate forms, shifts take a random five-bit amount
    for (int i = 0; i < 10; i++) begin
      if (i == 1) continue; // there is no subi
      if (f3_list[i] == 3'b001 || f3_list[i] == 3'b101)
        emit(enc_i(OPC_OP_IMM, {f7_list[i], 5'(rand_bits(5))}, 5'd1, f3_list[i],
                   reg_addr_t'(13 + i)));
      else
        emit(enc_i(OPC_OP_IMM, 12'(rand_bits(12)), 5'd2, f3_list[i], reg_addr_t'(13 + i)));
    end
    emit({20'(rand_bits(20)), 5'd25, OPC_LUI});
    emit(EBREAK_INST);
    run_program(1'b0);
  endtask

  task automatic test_chains();
    clear_program();
    emit(enc_i(OPC_OP_IMM, 12'(rand_bits(12)), 5'd0, 3'b000, 5'd1));
    emit(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2)); // distance one
    emit(enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd3)); // distances one and two
    emit(enc_i(OPC_OP_IMM, 12'(rand_bits(12)), 5'd0, 3'b000, 5'd4));
    emit(enc_r(7'h00, 5'd4, 5'd3, 3'b100, 5'd5));
    emit(enc_i(OPC_OP_IMM, 12'd1, 5'd0, 3'b000, 5'd6));
    emit(enc_i(OPC_OP_IMM, 12'd2, 5'd0, 3'b000, 5'd7));
    emit(enc_r(7'h00, 5'd6, 5'd5, 3'b110, 5'd8)); // x5 at distance three
    emit(enc_i(OPC_OP_IMM, 12'(rand_bits(12)), 5'd0, 3'b000, 5'd9));
    emit(enc_i(OPC_OP_IMM, 12'd4, 5'd0, 3'b000, 5'd10));
    emit(enc_i(OPC_OP_IMM, 12'd5, 5'd0, 3'b000, 5'd11));
    emit(enc_r(7'h00, 5'd9, 5'd8, 3'b111, 5'd12));
    emit(enc_r(7'h00, 5'd6, 5'd12, 3'b001, 5'd13));
    emit(EBREAK_INST);
    run_program(1'b0);
  endtask

  task automatic test_memory();
    clear_program();
    emit(enc_i(OPC_OP_IMM, 12'h040, 5'd0, 3'b000, 5'd1)); // base address
    load_const(5'd2, rand_bits(32));
    load_const(5'd3, rand_bits(32));
    emit(enc_s(12'd0, 5'd2, 5'd1));
    emit(enc_s(12'd8, 5'd3, 5'd1));
    emit(enc_s(12'hFFC, 5'd3, 5'd1)); // negative offset
    emit(enc_i(OPC_LOAD, 12'd0, 5'd1, 3'b010, 5'd4));
    emit(enc_i(OPC_LOAD, 12'd8, 5'd1, 3'b010, 5'd5));
    emit(enc_i(OPC_LOAD, 12'd4, 5'd1, 3'b010, 5'd6)); // never written, reads the fill
    emit(enc_i(OPC_OP_IMM, 12'd1, 5'd5, 3'b000, 5'd7)); // load result used right away
    emit(enc_s(12'd12, 5'd7, 5'd1));
    emit(enc_i(OPC_LOAD, 12'd12, 5'd1, 3'b010, 5'd8));
    emit(enc_i(OPC_LOAD, 12'hFFC, 5'd1, 3'b010, 5'd9));
    emit(EBREAK_INST);
    run_program(1'b0);
  endtask

  task automatic test_unsupported();
    clear_program();
    emit(enc_i(OPC_OP_IMM, 12'd9, 5'd0, 3'b000, 5'd1));
    emit({20'hABCDE, 5'd3, 7'b1111111});
    emit({20'h12345, 5'd4, 7'b0001111});
    emit(enc_r(7'h00, 5'd3, 5'd1, 3'b000, 5'd5)); // x3 must still read zero
    emit(EBREAK_INST);
    run_program(1'b0);
  endtask

  task automatic test_halt();
    clear_program();
    emit(enc_i(OPC_OP_IMM, 12'd1, 5'd0, 3'b000, 5'd1));
    emit(EBREAK_INST);
    emit(enc_i(OPC_OP_IMM, 12'd2, 5'd0, 3'b000, 5'd2)); // sits behind the halt
    emit(enc_i(OPC_OP_IMM, 12'd3, 5'd0, 3'b000, 5'd3));
    run_program(1'b0);
  endtask

  initial begin
    i_rst = 1'b1;
    mismatch_count = 0;
    failure_count = 0;
    lfsr_state = 32'd94;
    test_reset();
    test_alu();
    test_chains();
    test_memory();
    test_unsupported();
    test_halt();
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
hdl/hart_pkg.sv
hdl/stage_if.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/hazard_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/writeback_stage.sv
hdl/hart_top.sv
verif/hart_sva.sv
verif/tb_hart.sv

// File: Makefile
TOOL   = verilator
FLAGS  = --binary --timing --assert -j 0
TOP    = tb_hart
FLIST  = verilog.f
OBJDIR = obj_dir
BIN    = $(OBJDIR)/V$(TOP)
LOG    = sim.log
SRCS   = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
